// File: compile.f
hdl/rename_pkg.sv
hdl/inst_decode.sv
hdl/spec_map_table.sv
hdl/free_list.sv
hdl/retire_queue.sv
hdl/arch_map_table.sv
hdl/rename_top.sv
bench/rename_asserts.sv
bench/rename_tb.sv

// File: Bender.yml
package:
  name: rename_core

sources:
  - hdl/rename_pkg.sv
  - hdl/inst_decode.sv
  - hdl/spec_map_table.sv
  - hdl/free_list.sv
  - hdl/retire_queue.sv
  - hdl/arch_map_table.sv
  - hdl/rename_top.sv
  - target: test
    files:
      - bench/rename_asserts.sv
      - bench/rename_tb.sv

// File: bench/rename_tb.sv
`timescale 1ns/10ps
module rename_tb;
	import rename_pkg::*;

	localparam int ROB_DEPTH = 16;
	localparam int RETIRE_WIDTH = 2;
	localparam int CLOCK_PERIOD = 4;
	localparam int TOTAL_INST = 16 + 400;  // Directed fill plus random phase
	localparam int WATCHDOG_NS = TOTAL_INST * 40 * CLOCK_PERIOD;
	localparam int RC_BITS = $clog2(RETIRE_WIDTH + 1);

	typedef struct packed {
		renamed_t ren;
		logic     done;
	} rob_entry_t;

	logic clock;
	logic reset;
	logic inst_valid;
	logic [INST_BITS-1:0] inst;
	logic complete_valid;
	rob_tag_t complete_tag;
	logic rename_valid;
	renamed_t rename_out;
	logic full;
	logic [RC_BITS-1:0] retire_count;
	phys_reg_t [NUM_ARCH_REGS-1:0] arch_map;

	phys_reg_t [NUM_ARCH_REGS-1:0] spec_model;
	phys_reg_t [NUM_ARCH_REGS-1:0] arch_model;
	phys_reg_t free_q [$];
	rob_entry_t rob_q [$];  // Oldest first
	renamed_t exp_ren;
	logic accepted_last;
	rob_tag_t next_tag;

	rob_tag_t pending_tags [$];  // Issued writers still waiting for completion
	int issued;
	logic [15:0] lfsr = 16'd24;

	rename_top #(.ROB_DEPTH(ROB_DEPTH), .RETIRE_WIDTH(RETIRE_WIDTH)) u_rename_top (.*);

	bind rename_top rename_asserts #(.RETIRE_WIDTH(RETIRE_WIDTH)) u_rename_asserts (.*);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			value = {value[14:0], fb};
		end
		return value;
	endfunction

	function automatic logic writes_register(input logic [INST_BITS-1:0] word);
		return (word[2:0] inside {op_alu, op_alu_imm, op_load}) && (word[7:4] != 4'd0);
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	// Strobes last one cycle, then a quiet cycle so full reflects the accept
	task automatic run_step(input logic dispatch, input logic [INST_BITS-1:0] word,
			input logic complete, input rob_tag_t tag);
		@(posedge clock);
		inst_valid <= dispatch;
		inst <= word;
		complete_valid <= complete;
		complete_tag <= tag;
		@(posedge clock);
		inst_valid <= 1'b0;
		complete_valid <= 1'b0;
		if (dispatch && writes_register(word))
			pending_tags.push_back(rob_tag_t'(issued % ROB_DEPTH));
		if (dispatch)
			issued++;
		@(negedge clock);
	endtask

	task automatic complete_all(input logic youngest_first);
		int idx;
		rob_tag_t tag;
		while (pending_tags.size() != 0) begin
			if (youngest_first)
				idx = pending_tags.size() - 1;
			else
				idx = int'(random_bits(5)) % pending_tags.size();
			tag = pending_tags[idx];
			pending_tags.delete(idx);
			run_step(1'b0, '0, 1'b1, tag);
		end
		while (rob_q.size() != 0)
			@(negedge clock);
	endtask

	always @(posedge clock) begin
		rob_entry_t entry;
		int run;
		if (reset) begin
			for (int i = 0; i < NUM_ARCH_REGS; i++) begin
				spec_model[i] = phys_reg_t'(i);
				arch_model[i] = phys_reg_t'(i);
			end
			free_q.delete();
			for (int p = NUM_ARCH_REGS; p < NUM_PHYS_REGS; p++)
				free_q.push_back(phys_reg_t'(p));
			rob_q.delete();
			accepted_last = 1'b0;
			next_tag = '0;
		end else begin
			check_value("rename_valid", accepted_last, rename_valid);
			if (accepted_last)
				check_value("rename_out", exp_ren, rename_out);
			check_value("arch_map", arch_model, arch_map);
			check_value("full", free_q.size() == 0 || rob_q.size() == ROB_DEPTH, full);
			run = 0;  // Leading run of done entries
			while (run < RETIRE_WIDTH && run < rob_q.size() && rob_q[run].done)
				run++;
			check_value("retire_count", run, retire_count);
			accepted_last = inst_valid;
			if (inst_valid) begin
				exp_ren.phys_rs1 = spec_model[inst[11:8]];
				exp_ren.phys_rs2 = spec_model[inst[15:12]];
				exp_ren.phys_rd = free_q[0];
				exp_ren.old_rd = spec_model[inst[7:4]];
				exp_ren.rd = inst[7:4];
				exp_ren.writes_rd = writes_register(inst);
				exp_ren.tag = next_tag;
				next_tag = rob_tag_t'((next_tag + 1) % ROB_DEPTH);
				if (exp_ren.writes_rd)
					spec_model[inst[7:4]] = free_q.pop_front();
			end
			// Program order, so the youngest write to a register lands last
			for (int k = 0; k < run; k++) begin
				entry = rob_q.pop_front();
				if (entry.ren.writes_rd) begin
					arch_model[entry.ren.rd] = entry.ren.phys_rd;
					free_q.push_back(entry.ren.old_rd);
				end
			end
			if (complete_valid) begin
				foreach (rob_q[i])
					if (rob_q[i].ren.tag == complete_tag)
						rob_q[i].done = 1'b1;
			end
			if (inst_valid)
				rob_q.push_back({exp_ren, !exp_ren.writes_rd});
		end
	end

	always @(negedge clock) begin
		if (u_rename_top.u_rename_asserts.error_count != 0) begin
			$display("TESTS FAILED");
			$fatal(1, "A bound protocol assertion failed");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("TESTS FAILED");
		$fatal(1, "Watchdog expired before all instructions retired");
	end

	initial begin
		logic [INST_BITS-1:0] word;
		logic [15:0] pick;
		int fill_count;
		int idx;
		rob_tag_t tag;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		complete_valid = 1'b0;
		complete_tag = '0;
		issued = 0;
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);

		// Each pair of writes shares rd so the pair retires in one cycle
		fill_count = 0;
		while (!full) begin
			word = {4'(15 - fill_count), 4'(fill_count), 4'(1 + fill_count / 2), 1'b0, op_alu};
			run_step(1'b1, word, 1'b0, '0);
			fill_count++;
		end
		check_value("destination renames before full", 16, fill_count);
		complete_all(1'b1);

		while (issued < TOTAL_INST) begin
			pick = random_bits(2);
			word = random_bits(15);
			word = {word[14:3], 1'b0, word[2:0]};
			if (pick[1] && pending_tags.size() != 0) begin
				idx = int'(random_bits(5)) % pending_tags.size();
				tag = pending_tags[idx];
				pending_tags.delete(idx);
				run_step(pick[0] && !full, word, 1'b1, tag);
			end else begin
				run_step(pick[0] && !full, word, 1'b0, '0);
			end
		end
		complete_all(1'b0);

		if (u_rename_top.u_rename_asserts.error_count == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("TESTS FAILED");
			$fatal(1, "Bound assertions reported errors");
		end
	end

endmodule

// File: bench/rename_asserts.sv
`timescale 1ns/10ps
module rename_asserts #(
	parameter int RETIRE_WIDTH = 2
) (
	input logic                                                   clock,
	input logic                                                   reset,
	input logic                                                   inst_valid,
	input logic                                                   full,
	input logic                                                   rename_valid,
	input logic [$clog2(RETIRE_WIDTH+1)-1:0]                      retire_count,
	input rename_pkg::phys_reg_t [rename_pkg::NUM_ARCH_REGS-1:0] arch_map
);
	import rename_pkg::*;

	int error_count = 0;

	// No physical register mapped by two architectural registers
	function automatic logic map_unique(input phys_reg_t [NUM_ARCH_REGS-1:0] map);
		logic [NUM_PHYS_REGS-1:0] seen;
		seen = '0;
		for (int i = 0; i < NUM_ARCH_REGS; i++) begin
			if (seen[map[i]])
				return 1'b0;
			seen[map[i]] = 1'b1;
		end
		return 1'b1;
	endfunction

	idle_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !full && !rename_valid && retire_count == '0)
		else begin
			$error("Outputs not idle after reset");
			error_count++;
		end

	no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
		inst_valid |-> !full)
		else begin
			$error("inst_valid raised while full");
			error_count++;
		end

	rename_one_cycle: assert property (@(posedge clock) disable iff (reset)
		inst_valid |=> rename_valid)
		else begin
			$error("No rename result one cycle after dispatch");
			error_count++;
		end

	arch_map_distinct: assert property (@(posedge clock) disable iff (reset)
		map_unique(arch_map))
		else begin
			$error("Physical register mapped twice in arch_map");
			error_count++;
		end

endmodule

// File: hdl/rename_top.sv
`timescale 1ns/10ps
module rename_top #(
	parameter int ROB_DEPTH    = 16,
	parameter int RETIRE_WIDTH = 2
) (
	input  logic                                                   clock,
	input  logic                                                   reset,
	input  logic                                                   inst_valid,
	input  logic [rename_pkg::INST_BITS-1:0]                       inst,
	input  logic                                                   complete_valid,
	input  rename_pkg::rob_tag_t                                   complete_tag,
	output logic                                                   rename_valid,
	output rename_pkg::renamed_t                                   rename_out,
	output logic                                                   full,
	output logic [$clog2(RETIRE_WIDTH+1)-1:0]                      retire_count,
	output rename_pkg::phys_reg_t [rename_pkg::NUM_ARCH_REGS-1:0] arch_map
);
	import rename_pkg::*;

	localparam int IDX_BITS = $clog2(ROB_DEPTH);

	decoded_t dec;
	phys_reg_t phys_rs1;
	phys_reg_t phys_rs2;
	phys_reg_t old_rd;
	phys_reg_t free_head;
	logic free_empty;
	logic rob_full;
	logic take_dest;
	logic [IDX_BITS-1:0] next_idx;  // Tracks the retire queue tail
	renamed_t renamed;
	retire_t [RETIRE_WIDTH-1:0] retire_slots;
	logic [RETIRE_WIDTH-1:0] free_push_valid;
	phys_reg_t [RETIRE_WIDTH-1:0] free_push_reg;

	assign take_dest = inst_valid && dec.writes_rd;
	assign full = free_empty || rob_full;

	always_comb begin
		renamed.phys_rs1 = phys_rs1;
		renamed.phys_rs2 = phys_rs2;
		renamed.phys_rd = free_head;
		renamed.old_rd = old_rd;
		renamed.rd = dec.rd;
		renamed.writes_rd = dec.writes_rd;
		renamed.tag = rob_tag_t'(next_idx);
	end

	// Old registers of retiring writers go back to the free list
	always_comb begin
		for (int k = 0; k < RETIRE_WIDTH; k++) begin
			free_push_valid[k] = retire_slots[k].valid;
			free_push_reg[k] = retire_slots[k].t_old;
		end
	end

	inst_decode u_inst_decode (
		.inst (inst),
		.dec  (dec)
	);

	spec_map_table u_spec_map_table (
		.clock      (clock),
		.reset      (reset),
		.rs1        (dec.rs1),
		.rs2        (dec.rs2),
		.rd         (dec.rd),
		.write_en   (take_dest),
		.write_phys (free_head),
		.phys_rs1   (phys_rs1),
		.phys_rs2   (phys_rs2),
		.old_rd     (old_rd)
	);

	free_list #(
		.RETIRE_WIDTH (RETIRE_WIDTH)
	) u_free_list (
		.clock      (clock),
		.reset      (reset),
		.pop        (take_dest),
		.head       (free_head),
		.empty      (free_empty),
		.push_valid (free_push_valid),
		.push_reg   (free_push_reg)
	);

	retire_queue #(
		.ROB_DEPTH    (ROB_DEPTH),
		.RETIRE_WIDTH (RETIRE_WIDTH)
	) u_retire_queue (
		.clock          (clock),
		.reset          (reset),
		.push           (inst_valid),
		.push_entry     (renamed),
		.complete_valid (complete_valid),
		.complete_tag   (complete_tag),
		.full           (rob_full),
		.retire         (retire_slots),
		.retire_count   (retire_count)
	);

	arch_map_table #(
		.RETIRE_WIDTH (RETIRE_WIDTH)
	) u_arch_map_table (
		.clock    (clock),
		.reset    (reset),
		.retire   (retire_slots),
		.arch_map (arch_map)
	);

	always_ff @(posedge clock) begin
		if (reset) begin
			rename_valid <= 1'b0;
			next_idx <= '0;
		end else begin
			rename_valid <= inst_valid;
			if (inst_valid)
				next_idx <= next_idx + 1'b1;  // Wraps with the queue
		end
	end

	always_ff @(posedge clock) begin
		if (inst_valid)
			rename_out <= renamed;
	end

endmodule

// File: hdl/arch_map_table.sv
`timescale 1ns/10ps
module arch_map_table #(
	parameter int RETIRE_WIDTH = 2
) (
	input  logic                                                   clock,
	input  logic                                                   reset,
	input  rename_pkg::retire_t [RETIRE_WIDTH-1:0]                 retire,
	output rename_pkg::phys_reg_t [rename_pkg::NUM_ARCH_REGS-1:0] arch_map
);
	import rename_pkg::*;

	logic [RETIRE_WIDTH-1:0] live;  // Slots that still search the table
	phys_reg_t [RETIRE_WIDTH-1:0] eff_new;
	phys_reg_t [NUM_ARCH_REGS-1:0] map_next;

	// A younger slot whose t_old is an older slot's t_new renames the same register.
	// Its t_new is folded into the older slot and the younger slot stops searching.
	always_comb begin
		logic [RETIRE_WIDTH-1:0] dropped;
		phys_reg_t chain_end;
		dropped = '0;
		live = '0;
		chain_end = '0;
		for (int j = 0; j < RETIRE_WIDTH; j++) begin
			eff_new[j] = retire[j].t_new;
			if (retire[j].valid && !dropped[j]) begin
				live[j] = 1'b1;
				chain_end = retire[j].t_new;
				for (int k = j + 1; k < RETIRE_WIDTH; k++) begin
					if (retire[k].valid && !dropped[k] && retire[k].t_old == chain_end) begin
						chain_end = retire[k].t_new;
						dropped[k] = 1'b1;
					end
				end
				eff_new[j] = chain_end;  // Youngest mapping of the chain
			end
		end
	end

	// Each live t_old hits exactly one entry, the one still holding the old register
	always_comb begin
		map_next = arch_map;
		for (int i = 0; i < NUM_ARCH_REGS; i++) begin
			for (int j = 0; j < RETIRE_WIDTH; j++) begin
				if (live[j] && arch_map[i] == retire[j].t_old)
					map_next[i] = eff_new[j];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ARCH_REGS; i++) begin
				arch_map[i] <= phys_reg_t'(i);
			end
		end else begin
			arch_map <= map_next;
		end
	end

endmodule

// File: hdl/retire_queue.sv
`timescale 1ns/10ps
module retire_queue #(
	parameter int ROB_DEPTH    = 16,
	parameter int RETIRE_WIDTH = 2
) (
	input  logic                                        clock,
	input  logic                                        reset,
	input  logic                                        push,
	input  rename_pkg::renamed_t                        push_entry,
	input  logic                                        complete_valid,
	input  rename_pkg::rob_tag_t                        complete_tag,
	output logic                                        full,
	output rename_pkg::retire_t [RETIRE_WIDTH-1:0]      retire,
	output logic [$clog2(RETIRE_WIDTH+1)-1:0]           retire_count
);
	import rename_pkg::*;

	localparam int IDX_BITS = $clog2(ROB_DEPTH);
	localparam int CNT_BITS = IDX_BITS + 1;
	localparam int RC_BITS = $clog2(RETIRE_WIDTH + 1);

	renamed_t entries [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] done;
	logic [IDX_BITS-1:0] head;
	logic [CNT_BITS-1:0] count;

	logic [IDX_BITS-1:0] push_idx;
	logic [IDX_BITS-1:0] complete_idx;

	// The tag handed out at rename is the slot the entry lands in
	assign push_idx = push_entry.tag[IDX_BITS-1:0];
	assign complete_idx = complete_tag[IDX_BITS-1:0];
	assign full = (count == CNT_BITS'(ROB_DEPTH));

	// Leading run of done entries from the head, at most RETIRE_WIDTH long
	always_comb begin
		logic run;
		logic [IDX_BITS-1:0] slot;
		run = 1'b1;
		retire_count = '0;
		for (int k = 0; k < RETIRE_WIDTH; k++) begin
			slot = head + IDX_BITS'(k);
			run = run && (CNT_BITS'(k) < count) && done[slot];
			retire[k].valid = run && entries[slot].writes_rd;
			retire[k].t_new = entries[slot].phys_rd;
			retire[k].t_old = entries[slot].old_rd;
			retire_count = retire_count + RC_BITS'(run);
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			entries[push_idx] <= push_entry;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done <= '0;
			head <= '0;
			count <= '0;
		end else begin
			if (complete_valid)
				done[complete_idx] <= 1'b1;
			if (push)
				done[push_idx] <= !push_entry.writes_rd;  // Nothing to wait for
			head <= head + IDX_BITS'(retire_count);
			count <= count + CNT_BITS'(push) - CNT_BITS'(retire_count);
		end
	end

endmodule

// File: hdl/free_list.sv
`timescale 1ns/10ps
module free_list #(
	parameter int RETIRE_WIDTH = 2
) (
	input  logic                                     clock,
	input  logic                                     reset,
	input  logic                                     pop,
	output rename_pkg::phys_reg_t                    head,
	output logic                                     empty,
	input  logic [RETIRE_WIDTH-1:0]                  push_valid,
	input  rename_pkg::phys_reg_t [RETIRE_WIDTH-1:0] push_reg
);
	import rename_pkg::*;

	localparam int PTR_BITS = $clog2(NUM_PHYS_REGS);
	localparam int FREE_AT_RESET = NUM_PHYS_REGS - NUM_ARCH_REGS;

	phys_reg_t fifo [NUM_PHYS_REGS];
	logic [PTR_BITS-1:0] head_ptr;
	logic [PTR_BITS-1:0] tail_ptr;
	logic [PTR_BITS:0] count;  // Number of free registers held

	logic [PTR_BITS-1:0] push_addr [RETIRE_WIDTH];
	logic [PTR_BITS:0] push_total;

	assign head = fifo[head_ptr];
	assign empty = (count == '0);

	// Compact the valid pushes into consecutive slots from the tail
	always_comb begin
		push_total = '0;
		for (int k = 0; k < RETIRE_WIDTH; k++) begin
			push_addr[k] = tail_ptr + push_total[PTR_BITS-1:0];
			push_total = push_total + (PTR_BITS + 1)'(push_valid[k]);
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// Slots beyond the initial free count are empty; their contents never surface
			for (int i = 0; i < NUM_PHYS_REGS; i++) begin
				fifo[i] <= phys_reg_t'((NUM_ARCH_REGS + i) % NUM_PHYS_REGS);
			end
		end else begin
			for (int k = 0; k < RETIRE_WIDTH; k++) begin
				if (push_valid[k]) begin
					fifo[push_addr[k]] <= push_reg[k];
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head_ptr <= '0;
			tail_ptr <= PTR_BITS'(FREE_AT_RESET);
			count <= (PTR_BITS + 1)'(FREE_AT_RESET);
		end else begin
			if (pop)
				head_ptr <= head_ptr + 1'b1;
			tail_ptr <= tail_ptr + push_total[PTR_BITS-1:0];
			count <= count + push_total - (PTR_BITS + 1)'(pop);
		end
	end

endmodule

// File: hdl/spec_map_table.sv
`timescale 1ns/10ps
module spec_map_table (
	input  logic                  clock,
	input  logic                  reset,
	input  rename_pkg::arch_reg_t rs1,
	input  rename_pkg::arch_reg_t rs2,
	input  rename_pkg::arch_reg_t rd,
	input  logic                  write_en,
	input  rename_pkg::phys_reg_t write_phys,
	output rename_pkg::phys_reg_t phys_rs1,
	output rename_pkg::phys_reg_t phys_rs2,
	output rename_pkg::phys_reg_t old_rd
);
	import rename_pkg::*;

	phys_reg_t map [NUM_ARCH_REGS];

	// Reads see the table before this cycle's write
	assign phys_rs1 = map[rs1];
	assign phys_rs2 = map[rs2];
	assign old_rd = map[rd];  // Freed when this instruction retires

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ARCH_REGS; i++) begin
				map[i] <= phys_reg_t'(i);  // Identity mapping
			end
		end else if (write_en) begin
			map[rd] <= write_phys;
		end
	end

endmodule

// File: hdl/inst_decode.sv
`timescale 1ns/10ps
module inst_decode (
	input  logic [rename_pkg::INST_BITS-1:0] inst,
	output rename_pkg::decoded_t             dec
);
	import rename_pkg::*;

	logic rd_nonzero;

	assign rd_nonzero = (inst[7:4] != '0);

	// Field layout: opcode [2:0], bit 3 reserved, rd [7:4], rs1 [11:8], rs2 [15:12]
	always_comb begin
		dec.rd = inst[7:4];
		dec.rs1 = inst[11:8];
		dec.rs2 = inst[15:12];
		dec.uses_rs1 = 1'b0;
		dec.uses_rs2 = 1'b0;
		dec.writes_rd = 1'b0;
		case (inst[2:0])
			op_alu: begin
				dec.opcode = op_alu;
				dec.uses_rs1 = 1'b1;
				dec.uses_rs2 = 1'b1;
				dec.writes_rd = rd_nonzero;
			end
			op_alu_imm: begin
				dec.opcode = op_alu_imm;
				dec.uses_rs1 = 1'b1;
				dec.writes_rd = rd_nonzero;
			end
			op_load: begin
				dec.opcode = op_load;
				dec.uses_rs1 = 1'b1;  // Base address only
				dec.writes_rd = rd_nonzero;
			end
			op_store: begin
				dec.opcode = op_store;
				dec.uses_rs1 = 1'b1;
				dec.uses_rs2 = 1'b1;  // Store data
			end
			op_branch: begin
				dec.opcode = op_branch;
				dec.uses_rs1 = 1'b1;
				dec.uses_rs2 = 1'b1;
			end
			default: begin
				dec.opcode = op_nop;  // Unknown codes do nothing
			end
		endcase
	end

endmodule

// File: hdl/rename_pkg.sv
package rename_pkg;

	// Register file sizes
	localparam int NUM_ARCH_REGS = 16;
	localparam int NUM_PHYS_REGS = 32;
	localparam int ARCH_REG_BITS = $clog2(NUM_ARCH_REGS);
	localparam int PHYS_REG_BITS = $clog2(NUM_PHYS_REGS);

	localparam int INST_BITS = 16;

	// Tag is sized for the deepest supported retire queue; shallower queues use the low bits
	localparam int MAX_ROB_DEPTH = 32;
	localparam int ROB_TAG_BITS = $clog2(MAX_ROB_DEPTH);

	typedef logic [ARCH_REG_BITS-1:0] arch_reg_t;
	typedef logic [PHYS_REG_BITS-1:0] phys_reg_t;
	typedef logic [ROB_TAG_BITS-1:0] rob_tag_t;

	// Encoding of inst[2:0]; codes 5 and 6 decode as nop
	typedef enum logic [2:0] {
		op_alu     = 3'd0,
		op_alu_imm = 3'd1,
		op_load    = 3'd2,
		op_store   = 3'd3,
		op_branch  = 3'd4,
		op_nop     = 3'd7
	} opcode_e;

	typedef struct packed {
		opcode_e   opcode;
		arch_reg_t rs1;
		arch_reg_t rs2;
		arch_reg_t rd;
		logic      uses_rs1;
		logic      uses_rs2;
		logic      writes_rd;
	} decoded_t;

	typedef struct packed {
		phys_reg_t phys_rs1;
		phys_reg_t phys_rs2;
		phys_reg_t phys_rd;
		phys_reg_t old_rd;  // Mapping of rd before this instruction
		arch_reg_t rd;
		logic      writes_rd;
		rob_tag_t  tag;
	} renamed_t;

	// One retirement slot; valid only when the entry retires and writes a register
	typedef struct packed {
		logic      valid;
		phys_reg_t t_new;
		phys_reg_t t_old;
	} retire_t;

endpackage
